// ==== flist.f ====
hw/capture_pkg.sv
hw/dual_port_ram.sv
hw/async_fifo.sv
hw/channel_writer.sv
hw/wb_arbiter.sv
hw/frame_buffer.sv
hw/capture_top.sv
verif/tb_capture.sv

// ==== Bender.yml ====
package:
  name: capture_buffer

sources:
  - hw/capture_pkg.sv
  - hw/dual_port_ram.sv
  - hw/async_fifo.sv
  - hw/channel_writer.sv
  - hw/wb_arbiter.sv
  - hw/frame_buffer.sv
  - hw/capture_top.sv
  - target: simulation
    files:
      - verif/tb_capture.sv

// ==== verif/tb_capture.sv ====
`timescale 1ns/10ps

module tb_capture import capture_pkg::*; ();

  logic      wclk;
  logic      wrstn;
  logic      rclk;
  logic      rrstn;
  logic      ch0_winc;
  sample_t   ch0_wdata;
  logic      ch0_wfull;
  logic      ch1_winc;
  sample_t   ch1_wdata;
  logic      ch1_wfull;
  logic      host_cyc;
  logic      host_stb;
  logic      host_we;
  buf_addr_t host_adr;
  sample_t   host_dat_w;
  sample_t   host_dat_r;
  logic      host_ack;
  count_t    ch0_count;
  count_t    ch1_count;

  // reference model, accepted samples wait in the queues until stored.
  sample_t q0 [$];
  sample_t q1 [$];
  int      stored [2];
  sample_t exp_mem [buf_words];
  logic    exp_vld [buf_words];

  logic [31:0] rng_state = 32'd22769;
  int          wait_limit = 4000; // cycles per wait loop.
  int          errors;
  int          checks;
  int          test_errors_base;
  int          tests_failed;
  logic        ch0_full_seen;

  capture_top dut_i (
    .wclk       (wclk),
    .wrstn      (wrstn),
    .rclk       (rclk),
    .rrstn      (rrstn),
    .ch0_winc   (ch0_winc),
    .ch0_wdata  (ch0_wdata),
    .ch0_wfull  (ch0_wfull),
    .ch1_winc   (ch1_winc),
    .ch1_wdata  (ch1_wdata),
    .ch1_wfull  (ch1_wfull),
    .host_cyc   (host_cyc),
    .host_stb   (host_stb),
    .host_we    (host_we),
    .host_adr   (host_adr),
    .host_dat_w (host_dat_w),
    .host_dat_r (host_dat_r),
    .host_ack   (host_ack),
    .ch0_count  (ch0_count),
    .ch1_count  (ch1_count)
  );

  initial begin
    rclk = 1'b0;
    forever #5 rclk = ~rclk;
  end

  // faster producer so the FIFOs fill.
  initial begin
    wclk = 1'b0;
    forever #2 wclk = ~wclk;
  end

  function automatic sample_t next_sample();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[15:0];
  endfunction

  function automatic logic is_full(input int ch);
    return (ch == 0) ? ch0_wfull : ch1_wfull;
  endfunction

  function automatic count_t count_of(input int ch);
    return (ch == 0) ? ch0_count : ch1_count;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(negedge rclk);
    rrstn = 1'b0;
    wrstn = 1'b0;
    repeat (5) @(negedge rclk);
    rrstn = 1'b1;
    @(negedge wclk);
    wrstn = 1'b1;
    stored[0] = 0; // ring index restarts.
    stored[1] = 0;
  endtask

  task automatic push_sample(input int ch, input sample_t d);
    int waited;
    waited = 0;
    @(negedge wclk);
    while (is_full(ch) && waited < wait_limit) begin
      if (ch == 0) ch0_full_seen = 1'b1;
      @(negedge wclk);
      waited++;
    end
    if (is_full(ch)) begin
      $display("timeout: channel %0d FIFO stayed full", ch);
      errors++;
    end else begin
      if (ch == 0) begin
        ch0_winc  = 1'b1;
        ch0_wdata = d;
        q0.push_back(d);
      end else begin
        ch1_winc  = 1'b1;
        ch1_wdata = d;
        q1.push_back(d);
      end
      @(negedge wclk);
      ch0_winc = (ch == 0) ? 1'b0 : ch0_winc;
      ch1_winc = (ch == 1) ? 1'b0 : ch1_winc;
    end
  endtask

  task automatic wait_count(input int ch, input int n);
    int waited;
    waited = 0;
    while (count_of(ch) != count_t'(n) && waited < wait_limit) begin
      @(negedge rclk);
      waited++;
    end
    if (count_of(ch) != count_t'(n)) begin
      $display("timeout: ch%0d_count never reached %0d", ch, n);
      errors++;
    end
  endtask

  // each stored sample lands at base plus ring index.
  task automatic drain_model(input int ch);
    sample_t d;
    int      adr;
    while ((ch == 0) ? (q0.size() > 0) : (q1.size() > 0)) begin
      d   = (ch == 0) ? q0.pop_front() : q1.pop_front();
      adr = ch * region_words + stored[ch] % region_words;
      exp_mem[adr] = d;
      exp_vld[adr] = 1'b1;
      stored[ch]++;
    end
  endtask

  task automatic host_transfer(input logic we, input buf_addr_t adr, input sample_t wdat,
                               output sample_t rdat);
    int waited;
    waited = 0;
    @(negedge rclk);
    host_cyc   = 1'b1;
    host_stb   = 1'b1;
    host_we    = we;
    host_adr   = adr;
    host_dat_w = wdat;
    do begin
      @(negedge rclk);
      waited++;
    end while (!host_ack && waited < wait_limit);
    if (!host_ack) begin
      $display("timeout: host transfer to word %0d got no ack", adr);
      errors++;
    end
    rdat     = host_dat_r;
    host_cyc = 1'b0;
    host_stb = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic check_word(input int adr);
    sample_t got;
    host_transfer(1'b0, buf_addr_t'(adr), '0, got);
    check_value(got, exp_mem[adr], $sformatf("word %0d", adr));
  endtask

  task automatic finish_test(input int num, input string name);
    if (errors == test_errors_base) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      $display("test %0d %s: fail, %0d errors", num, name, errors - test_errors_base);
      tests_failed++;
    end
    test_errors_base = errors;
  endtask

  initial begin
    sample_t d;
    sample_t rd;
    int      reads;
    int      n0_end;
    int      n1_end;
    wrstn = 1'b0;
    rrstn = 1'b0;
    ch0_winc = 1'b0;
    ch0_wdata = '0;
    ch1_winc = 1'b0;
    ch1_wdata = '0;
    host_cyc = 1'b0;
    host_stb = 1'b0;
    host_we = 1'b0;
    host_adr = '0;
    host_dat_w = '0;
    errors = 0;
    checks = 0;
    test_errors_base = 0;
    tests_failed = 0;
    ch0_full_seen = 1'b0;
    for (int a = 0; a < buf_words; a++) begin
      exp_mem[a] = '0;
      exp_vld[a] = 1'b0;
    end
    apply_reset();

    check_value(ch0_count, 0, "ch0_count after reset");
    check_value(ch1_count, 0, "ch1_count after reset");
    check_value(ch0_wfull, 0, "ch0_wfull after reset");
    check_value(ch1_wfull, 0, "ch1_wfull after reset");
    check_value(host_ack, 0, "host_ack after reset");
    finish_test(1, "reset state");

    for (int i = 0; i < 8; i++) begin
      push_sample(0, next_sample());
    end
    wait_count(0, 8);
    check_value(ch0_count, 8, "ch0_count");
    drain_model(0);
    for (int a = 0; a < 8; a++) begin
      check_word(a);
    end
    finish_test(2, "channel 0 transfer");

    for (int i = 0; i < 5; i++) begin
      push_sample(1, next_sample());
    end
    wait_count(1, 5);
    check_value(ch1_count, 5, "ch1_count");
    drain_model(1);
    for (int a = 32; a < 37; a++) begin
      check_word(a);
    end
    for (int a = 0; a < 8; a++) begin
      check_word(a); // channel 0 untouched.
    end
    finish_test(3, "channel 1 transfer");

    n0_end = stored[0] + 12;
    n1_end = stored[1] + 12;
    fork
      begin
        for (int i = 0; i < 12; i++) begin
          push_sample(0, next_sample());
        end
      end
      begin
        for (int i = 0; i < 12; i++) begin
          push_sample(1, next_sample());
        end
      end
      begin
        // host keeps the bus busy until both writers finish.
        reads = 0;
        while ((ch0_count != count_t'(n0_end) || ch1_count != count_t'(n1_end))
               && reads < 500) begin
          host_transfer(1'b0, buf_addr_t'(reads), '0, d);
          reads++;
        end
      end
    join
    wait_count(0, n0_end);
    wait_count(1, n1_end);
    check_value(ch0_count, n0_end, "ch0_count under contention");
    check_value(ch1_count, n1_end, "ch1_count under contention");
    drain_model(0);
    drain_model(1);
    for (int a = 0; a < buf_words; a++) begin
      if (exp_vld[a]) check_word(a);
    end
    finish_test(4, "contention");

    apply_reset();
    ch0_full_seen = 1'b0;
    for (int i = 0; i < 40; i++) begin
      push_sample(0, next_sample());
    end
    checks++;
    assert (ch0_full_seen) else begin
      $display("ch0_wfull never went high during the 40 sample burst");
      errors++;
    end
    wait_count(0, 40);
    check_value(ch0_count, 40, "ch0_count after wrap");
    drain_model(0);
    for (int a = 0; a < region_words; a++) begin
      check_word(a);
    end
    finish_test(5, "back-pressure and wrap");

    d = next_sample();
    host_transfer(1'b1, buf_addr_t'(40), d, rd);
    exp_mem[40] = d;
    exp_vld[40] = 1'b1;
    check_word(40);
    finish_test(6, "host write");

    $display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/capture_top.sv ====
`timescale 1ns/10ps

module capture_top import capture_pkg::*; (
  input  logic      wclk,
  input  logic      wrstn,
  input  logic      rclk,
  input  logic      rrstn,
  input  logic      ch0_winc,
  input  sample_t   ch0_wdata,
  output logic      ch0_wfull,
  input  logic      ch1_winc,
  input  sample_t   ch1_wdata,
  output logic      ch1_wfull,
  input  logic      host_cyc,
  input  logic      host_stb,
  input  logic      host_we,
  input  buf_addr_t host_adr,
  input  sample_t   host_dat_w,
  output sample_t   host_dat_r,
  output logic      host_ack,
  output count_t    ch0_count,
  output count_t    ch1_count
);

  logic                 rempty [2];
  logic                 rinc [2];
  sample_t              fifo_rdata [2];
  logic                 w_cyc [2];
  logic                 w_stb [2];
  logic                 w_we [2];
  buf_addr_t            w_adr [2];
  sample_t              w_dat_w [2];
  logic [n_masters-1:0] m_ack;
  sample_t              m_dat_r;
  logic                 s_cyc;
  logic                 s_stb;
  logic                 s_we;
  buf_addr_t            s_adr;
  sample_t              s_dat_w;
  sample_t              s_dat_r;
  logic                 s_ack;

  async_fifo fifo0_i (
    .wclk   (wclk),
    .wrstn  (wrstn),
    .rclk   (rclk),
    .rrstn  (rrstn),
    .winc   (ch0_winc),
    .rinc   (rinc[0]),
    .wdata  (ch0_wdata),
    .wfull  (ch0_wfull),
    .rempty (rempty[0]),
    .rdata  (fifo_rdata[0])
  );

  async_fifo fifo1_i (
    .wclk   (wclk),
    .wrstn  (wrstn),
    .rclk   (rclk),
    .rrstn  (rrstn),
    .winc   (ch1_winc),
    .rinc   (rinc[1]),
    .wdata  (ch1_wdata),
    .wfull  (ch1_wfull),
    .rempty (rempty[1]),
    .rdata  (fifo_rdata[1])
  );

  channel_writer #(.channel(0)) writer0_i (
    .rclk       (rclk),
    .rrstn      (rrstn),
    .rempty     (rempty[0]),
    .fifo_rdata (fifo_rdata[0]),
    .rinc       (rinc[0]),
    .wb_cyc     (w_cyc[0]),
    .wb_stb     (w_stb[0]),
    .wb_we      (w_we[0]),
    .wb_adr     (w_adr[0]),
    .wb_dat_w   (w_dat_w[0]),
    .wb_ack     (m_ack[0]),
    .count      (ch0_count)
  );

  channel_writer #(.channel(1)) writer1_i (
    .rclk       (rclk),
    .rrstn      (rrstn),
    .rempty     (rempty[1]),
    .fifo_rdata (fifo_rdata[1]),
    .rinc       (rinc[1]),
    .wb_cyc     (w_cyc[1]),
    .wb_stb     (w_stb[1]),
    .wb_we      (w_we[1]),
    .wb_adr     (w_adr[1]),
    .wb_dat_w   (w_dat_w[1]),
    .wb_ack     (m_ack[1]),
    .count      (ch1_count)
  );

  // host is master 2.
  wb_arbiter arb_i (
    .rclk     (rclk),
    .rrstn    (rrstn),
    .m_cyc    ({host_cyc, w_cyc[1], w_cyc[0]}),
    .m_stb    ({host_stb, w_stb[1], w_stb[0]}),
    .m_we     ({host_we, w_we[1], w_we[0]}),
    .m_adr0   (w_adr[0]),
    .m_adr1   (w_adr[1]),
    .m_adr2   (host_adr),
    .m_dat_w0 (w_dat_w[0]),
    .m_dat_w1 (w_dat_w[1]),
    .m_dat_w2 (host_dat_w),
    .m_ack    (m_ack),
    .m_dat_r  (m_dat_r),
    .s_cyc    (s_cyc),
    .s_stb    (s_stb),
    .s_we     (s_we),
    .s_adr    (s_adr),
    .s_dat_w  (s_dat_w),
    .s_dat_r  (s_dat_r),
    .s_ack    (s_ack)
  );

  assign host_ack   = m_ack[2];
  assign host_dat_r = m_dat_r;

  frame_buffer buf_i (
    .rclk  (rclk),
    .rrstn (rrstn),
    .cyc   (s_cyc),
    .stb   (s_stb),
    .we    (s_we),
    .adr   (s_adr),
    .dat_w (s_dat_w),
    .dat_r (s_dat_r),
    .ack   (s_ack)
  );

endmodule

// ==== hw/frame_buffer.sv ====
`timescale 1ns/10ps

module frame_buffer import capture_pkg::*; (
  input  logic      rclk,
  input  logic      rrstn,
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  buf_addr_t adr,
  input  sample_t   dat_w,
  output sample_t   dat_r,
  output logic      ack
);

  sample_t mem [buf_words];
  logic    hit;

  // new request, not the cycle that already acks it.
  assign hit = cyc & stb & ~ack;

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      ack <= 1'b0;
    end else begin
      ack <= hit;
    end
  end

  always_ff @(posedge rclk) begin
    if (hit) begin
      if (we) begin
        mem[adr] <= dat_w;
      end
      dat_r <= mem[adr]; // old word on a write.
    end
  end

endmodule

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/10ps

module wb_arbiter import capture_pkg::*; (
  input  logic                 rclk,
  input  logic                 rrstn,
  input  logic [n_masters-1:0] m_cyc,
  input  logic [n_masters-1:0] m_stb,
  input  logic [n_masters-1:0] m_we,
  input  buf_addr_t            m_adr0,
  input  buf_addr_t            m_adr1,
  input  buf_addr_t            m_adr2,
  input  sample_t              m_dat_w0,
  input  sample_t              m_dat_w1,
  input  sample_t              m_dat_w2,
  output logic [n_masters-1:0] m_ack,
  output sample_t              m_dat_r,
  output logic                 s_cyc,
  output logic                 s_stb,
  output logic                 s_we,
  output buf_addr_t            s_adr,
  output sample_t              s_dat_w,
  input  sample_t              s_dat_r,
  input  logic                 s_ack
);

  arb_state_t  state;
  master_idx_t gnt; // also the last-grant pointer.
  master_idx_t pick;
  logic        pick_vld;
  logic        owned;

  // first requester after the last grant.
  always_comb begin : rr_pick
    int cand;
    pick     = gnt;
    pick_vld = 1'b0;
    for (int i = 1; i <= n_masters; i++) begin
      cand = int'(gnt) + i;
      if (cand >= n_masters) begin
        cand = cand - n_masters;
      end
      if (!pick_vld && m_cyc[cand]) begin
        pick     = master_idx_t'(cand);
        pick_vld = 1'b1;
      end
    end
  end

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      state <= free;
      gnt   <= master_idx_t'(n_masters - 1); // channel 0 goes first.
    end else begin
      case (state)
        free: begin
          if (pick_vld) begin
            state <= granted;
            gnt   <= pick;
          end
        end
        granted: begin
          if (!m_cyc[gnt]) begin
            state <= free;
          end
        end
        default: begin
          state <= free;
        end
      endcase
    end
  end

  assign owned = (state == granted);

  always_comb begin
    case (gnt)
      2'd0: begin
        s_adr   = m_adr0;
        s_dat_w = m_dat_w0;
      end
      2'd1: begin
        s_adr   = m_adr1;
        s_dat_w = m_dat_w1;
      end
      default: begin
        s_adr   = m_adr2;
        s_dat_w = m_dat_w2;
      end
    endcase
  end

  assign s_cyc = owned & m_cyc[gnt];
  assign s_stb = owned & m_stb[gnt];
  assign s_we  = m_we[gnt];

  // ack goes back to the owner only.
  always_comb begin
    m_ack = '0;
    if (owned) begin
      m_ack[gnt] = s_ack;
    end
  end

  assign m_dat_r = s_dat_r;

endmodule

// ==== hw/channel_writer.sv ====
`timescale 1ns/10ps

module channel_writer import capture_pkg::*; #(
  parameter int channel = 0
) (
  input  logic      rclk,
  input  logic      rrstn,
  input  logic      rempty,
  input  sample_t   fifo_rdata,
  output logic      rinc,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output buf_addr_t wb_adr,
  output sample_t   wb_dat_w,
  input  logic      wb_ack,
  output count_t    count
);

  writer_state_t state;
  region_idx_t   idx;
  sample_t       sample_q;

  // pop only from idle, so a stalled bus backs up the FIFO.
  assign rinc = (state == idle) & ~rempty;

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      state <= idle;
      idx   <= '0;
      count <= '0;
    end else begin
      case (state)
        idle: begin
          if (!rempty) begin
            state <= fetch;
          end
        end
        fetch: begin
          state <= bus;
        end
        bus: begin
          if (wb_ack) begin
            state <= idle;
            idx   <= idx + 1'b1; // ring wraps at region_words.
            count <= count + 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ram output is valid in fetch.
  always_ff @(posedge rclk) begin
    if (state == fetch) begin
      sample_q <= fifo_rdata;
    end
  end

  assign wb_cyc   = (state == bus);
  assign wb_stb   = (state == bus);
  assign wb_we    = 1'b1; // writes only.
  assign wb_dat_w = sample_q;

  // region base plus ring index.
  assign wb_adr = buf_addr_t'(channel * region_words) + buf_addr_t'(idx);

endmodule

// ==== hw/async_fifo.sv ====
`timescale 1ns/10ps

module async_fifo import capture_pkg::*; (
  input  logic    wclk,
  input  logic    wrstn,
  input  logic    rclk,
  input  logic    rrstn,
  input  logic    winc,
  input  logic    rinc,
  input  sample_t wdata,
  output logic    wfull,
  output logic    rempty,
  output sample_t rdata
);

  fifo_ptr_t wbin;
  fifo_ptr_t rbin;
  fifo_ptr_t wgray_cur;
  fifo_ptr_t rgray_cur;
  fifo_ptr_t wgray;
  fifo_ptr_t rgray;
  fifo_ptr_t wgray_meta;
  fifo_ptr_t wgray_sync;
  fifo_ptr_t rgray_meta;
  fifo_ptr_t rgray_sync;
  logic      wen;
  logic      ren;

  assign wen = winc & ~wfull;
  assign ren = rinc & ~rempty;

  assign wgray_cur = wbin ^ (wbin >> 1);
  assign rgray_cur = rbin ^ (rbin >> 1);

  // write domain pointer and its gray copy.
  always_ff @(posedge wclk or negedge wrstn) begin
    if (!wrstn) begin
      wbin  <= '0;
      wgray <= '0;
    end else begin
      if (wen) begin
        wbin <= wbin + 1'b1;
      end
      wgray <= wgray_cur; // only this copy crosses.
    end
  end

  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      rbin  <= '0;
      rgray <= '0;
    end else begin
      if (ren) begin
        rbin <= rbin + 1'b1;
      end
      rgray <= rgray_cur;
    end
  end

  // read pointer into the write domain.
  always_ff @(posedge wclk or negedge wrstn) begin
    if (!wrstn) begin
      rgray_meta <= '0;
      rgray_sync <= '0;
    end else begin
      rgray_meta <= rgray;
      rgray_sync <= rgray_meta;
    end
  end

  // write pointer into the read domain.
  always_ff @(posedge rclk or negedge rrstn) begin
    if (!rrstn) begin
      wgray_meta <= '0;
      wgray_sync <= '0;
    end else begin
      wgray_meta <= wgray;
      wgray_sync <= wgray_meta;
    end
  end

  // full when the write side is one lap ahead.
  assign wfull  = (wgray_cur == {~rgray_sync[fifo_aw:fifo_aw-1], rgray_sync[fifo_aw-2:0]});
  assign rempty = (rgray_cur == wgray_sync);

  dual_port_ram ram_i (
    .wclk  (wclk),
    .wenc  (wen),
    .waddr (wbin[fifo_aw-1:0]),
    .wdata (wdata),
    .rclk  (rclk),
    .renc  (ren),
    .raddr (rbin[fifo_aw-1:0]),
    .rdata (rdata)
  );

endmodule

// ==== hw/dual_port_ram.sv ====
`timescale 1ns/10ps

module dual_port_ram import capture_pkg::*; (
  input  logic               wclk,
  input  logic               wenc,
  input  logic [fifo_aw-1:0] waddr,
  input  sample_t            wdata,
  input  logic               rclk,
  input  logic               renc,
  input  logic [fifo_aw-1:0] raddr,
  output sample_t            rdata
);

  sample_t mem [fifo_depth];

  always_ff @(posedge wclk) begin
    if (wenc) begin
      mem[waddr] <= wdata;
    end
  end

  // read data holds until the next pop.
  always_ff @(posedge rclk) begin
    if (renc) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// ==== hw/capture_pkg.sv ====
package capture_pkg;

  // sample path.
  localparam int sample_w = 16;
  typedef logic [sample_w-1:0] sample_t;

  // per-channel FIFO, pointers carry one extra wrap bit.
  localparam int fifo_depth = 16;
  localparam int fifo_aw    = 4;
  typedef logic [fifo_aw:0] fifo_ptr_t;

  // frame buffer and the two ring regions.
  localparam int buf_words    = 64;
  localparam int buf_aw       = 6;
  localparam int region_words = 32;
  localparam int region_aw    = 5;
  typedef logic [buf_aw-1:0]    buf_addr_t;
  typedef logic [region_aw-1:0] region_idx_t;

  typedef logic [15:0] count_t; // wraps.

  // 0 and 1 are the channel writers, 2 is the host.
  localparam int n_masters = 3;
  localparam int master_aw = 2;
  typedef logic [master_aw-1:0] master_idx_t;

  typedef enum logic [1:0] {idle, fetch, bus} writer_state_t;
  typedef enum logic {free, granted} arb_state_t;

endpackage
